// File: lenet_conv_top.f
lenet_pkg.sv
lenet_xwyf_34.sv
lenet_conv_mac.sv
lenet_wb_regs.sv
lenet_conv_top.sv
tb_lenet_conv_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_lenet_conv_top \
    -f lenet_conv_top.f \
    -o sim_lenet_conv

./obj_dir/sim_lenet_conv 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: tb_lenet_conv_top.sv
`timescale 1ns/1ps

module tb_lenet_conv_top;

    localparam int timeout_cycles = 20000;

    logic                                clk;
    logic                                reset;
    logic                                wb_cyc;
    logic                                wb_stb;
    logic                                wb_we;
    logic [lenet_pkg::wb_addr_width-1:0] wb_adr;
    logic [lenet_pkg::wb_data_width-1:0] wb_dat_w;
    logic [lenet_pkg::wb_data_width-1:0] wb_dat_r;
    logic                                wb_ack;

    int unsigned cycle_count = 0;
    int unsigned ack_cycle;
    logic [7:0]  weights [lenet_pkg::num_taps];
    logic [7:0]  pixels [lenet_pkg::num_taps];
    logic [23:0] bias_val;
    logic [3:0]  shift_val;

    lenet_conv_top dut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("ERROR: run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic wb_write(input logic [7:0] addr, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        ack_cycle = cycle_count; // edge that took the write
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        wb_read(addr, rd);
        check_eq(name, rd, exp);
    endtask

    task automatic wait_until(input int unsigned target);
        while (cycle_count < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic int unsigned weighted_bit(input logic b, input int pos);
        return b ? (32'd1 << pos) : 32'd0;
    endfunction

    // approximate multiplier, rows 6 and 7 exact plus the correction terms
    function automatic int unsigned approx_mult(input logic [7:0] x, input logic [7:0] y);
        logic [7:0]  pp [8];
        int unsigned z;
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
        z = (32'(pp[6]) << 6) + (32'(pp[7]) << 7);
        z += weighted_bit(pp[0][3] & pp[1][2], 3);
        z += weighted_bit(pp[2][1] & pp[3][0], 4);
        z += weighted_bit(pp[2][3] ^ pp[3][2], 5);
        z += weighted_bit(pp[2][4] ^ pp[3][3], 6);
        z += weighted_bit(pp[2][5] & pp[3][4], 7);
        z += weighted_bit(pp[0][7] | pp[1][6], 8);
        z += weighted_bit(pp[2][7] | pp[3][6], 9);
        z += weighted_bit(pp[2][7] & pp[3][6], 10);
        z += weighted_bit(pp[4][7] & pp[5][6], 11);
        z += weighted_bit(pp[5][7], 12);
        z += weighted_bit(pp[2][1] & pp[3][0], 3);
        z += weighted_bit(pp[2][2] | pp[3][1], 4);
        z += weighted_bit(pp[4][2] ^ pp[5][1], 6);
        z += weighted_bit(pp[4][3] | pp[5][2], 7);
        z += weighted_bit(pp[2][5] | pp[3][4], 8);
        z += weighted_bit(pp[4][4] & pp[5][3], 9);
        z += weighted_bit(pp[3][7], 10);
        z += weighted_bit(pp[4][7] | pp[5][6], 11);
        z += weighted_bit(pp[2][6] | pp[3][5], 8);
        z += weighted_bit(pp[4][5] ^ pp[5][4], 9);
        z += weighted_bit(pp[4][5] & pp[5][4], 10);
        z += weighted_bit(pp[4][3] & pp[5][2], 8);
        z += weighted_bit(pp[4][6] & pp[5][5], 10);
        z += weighted_bit(pp[4][4] ^ pp[5][3], 8);
        z += weighted_bit(pp[4][6] | pp[5][5], 10);
        return z & 32'h0000_ffff; // 16 bit product
    endfunction

    function automatic logic [31:0] expected_acc();
        int unsigned sum;
        sum = 32'(bias_val);
        for (int i = 0; i < lenet_pkg::num_taps; i++) begin
            sum += approx_mult(weights[i], pixels[i]);
        end
        return sum & 32'h00ff_ffff;
    endfunction

    function automatic logic [31:0] expected_act(input logic [31:0] acc_val,
                                                 input logic [3:0] sh);
        logic [31:0] shifted;
        shifted = acc_val >> sh;
        if (shifted > 32'd255) begin
            return 32'd255;
        end else begin
            return shifted;
        end
    endfunction

    task automatic randomize_kernel();
        for (int i = 0; i < lenet_pkg::num_taps; i++) begin
            weights[i] = 8'($urandom);
            pixels[i]  = 8'($urandom);
        end
        bias_val  = 24'($urandom % 65536);
        shift_val = 4'($urandom);
    endtask

    task automatic load_kernel();
        for (int i = 0; i < lenet_pkg::num_taps; i++) begin
            wb_write(lenet_pkg::weight_base + 8'(i), 32'(weights[i]));
            wb_write(lenet_pkg::pixel_base + 8'(i), 32'(pixels[i]));
        end
        wb_write(lenet_pkg::reg_bias, 32'(bias_val));
        wb_write(lenet_pkg::reg_shift, 32'(shift_val));
    endtask

    task automatic wait_for_done();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (status[1] == 1'b0 && polls < 64) begin
            wb_read(lenet_pkg::reg_status, status);
            polls++;
        end
        if (status[1] == 1'b0) begin
            abort_run("engine never reported done");
        end
    endtask

    task automatic run_engine();
        wb_write(lenet_pkg::reg_ctrl, 32'h1);
        wait_for_done();
    endtask

    task automatic check_results();
        logic [31:0] acc_exp;
        acc_exp = expected_acc();
        read_check("acc", lenet_pkg::reg_acc, acc_exp);
        read_check("act", lenet_pkg::reg_act, expected_act(acc_exp, shift_val));
    endtask

    task automatic test_register_access();
        read_check("status", lenet_pkg::reg_status, 32'h0); // idle after reset
        randomize_kernel();
        bias_val = 24'($urandom);
        load_kernel();
        read_check("shift", lenet_pkg::reg_shift, 32'(shift_val));
        read_check("bias", lenet_pkg::reg_bias, 32'(bias_val));
        for (int i = 0; i < lenet_pkg::num_taps; i++) begin
            read_check($sformatf("weight[%0d]", i), lenet_pkg::weight_base + 8'(i),
                       32'(weights[i]));
            read_check($sformatf("pixel[%0d]", i), lenet_pkg::pixel_base + 8'(i),
                       32'(pixels[i]));
        end
        read_check("unmapped 0x06", 8'h06, 32'h0);
        read_check("unmapped 0x1f", 8'h1f, 32'h0);
        read_check("unmapped 0x39", 8'h39, 32'h0);
        read_check("unmapped 0x59", 8'h59, 32'h0);
        read_check("unmapped 0xff", 8'hff, 32'h0);
    endtask

    task automatic test_exact_products();
        int unsigned true_sum;
        randomize_kernel();
        true_sum = 32'(bias_val);
        for (int i = 0; i < lenet_pkg::num_taps; i++) begin
            weights[i] = {2'($urandom), 6'b000000}; // low six bits zero
            true_sum += 32'(weights[i]) * 32'(pixels[i]);
        end
        load_kernel();
        run_engine();
        read_check("exact acc", lenet_pkg::reg_acc, true_sum);
        read_check("exact act", lenet_pkg::reg_act, expected_act(true_sum, shift_val));
    endtask

    task automatic test_zero_operands();
        randomize_kernel();
        for (int i = 0; i < lenet_pkg::num_taps; i++) begin
            weights[i] = 8'h00;
        end
        load_kernel();
        run_engine();
        read_check("acc zero weights", lenet_pkg::reg_acc, 32'(bias_val));
        randomize_kernel();
        for (int i = 0; i < lenet_pkg::num_taps; i++) begin
            pixels[i] = 8'h00;
        end
        load_kernel();
        run_engine();
        read_check("acc zero pixels", lenet_pkg::reg_acc, 32'(bias_val));
    endtask

    task automatic test_run_timing();
        int unsigned start_edge;
        randomize_kernel();
        load_kernel();
        wb_write(lenet_pkg::reg_ctrl, 32'h1);
        start_edge = ack_cycle;
        read_check("status early", lenet_pkg::reg_status, 32'h1); // busy
        wait_until(start_edge + 26);
        read_check("status late", lenet_pkg::reg_status, 32'h1); // still draining
        wait_until(start_edge + 28);
        read_check("status done", lenet_pkg::reg_status, 32'h2);
        check_results();
    endtask

    task automatic test_shift_saturation();
        for (int i = 0; i < lenet_pkg::num_taps; i++) begin
            weights[i] = 8'hc0;
            pixels[i]  = 8'hff;
        end
        bias_val  = 24'($urandom % 65536);
        shift_val = 4'd0;
        load_kernel();
        run_engine();
        read_check("sat acc", lenet_pkg::reg_acc, expected_acc());
        read_check("sat act", lenet_pkg::reg_act, 32'd255);
        shift_val = 4'd15;
        wb_write(lenet_pkg::reg_shift, 32'(shift_val));
        run_engine();
        read_check("shift acc", lenet_pkg::reg_acc, expected_acc());
        read_check("shift act", lenet_pkg::reg_act, expected_acc() >> 15);
    endtask

    task automatic test_busy_writes();
        logic [7:0] first_weight;
        randomize_kernel();
        load_kernel();
        first_weight = weights[0];
        wb_write(lenet_pkg::reg_ctrl, 32'h1);
        wb_write(lenet_pkg::weight_base, 32'(~first_weight));
        wb_write(lenet_pkg::pixel_base + 8'd3, 32'(~pixels[3]));
        wb_write(lenet_pkg::reg_bias, 32'(~bias_val));
        wb_write(lenet_pkg::reg_ctrl, 32'h1); // restart while busy
        wait_for_done();
        check_results();
        read_check("weight[0] kept", lenet_pkg::weight_base, 32'(first_weight));
        run_engine();
        check_results();
        randomize_kernel();
        load_kernel();
        run_engine();
        check_results();
    endtask

    initial begin
        void'($urandom(32'h775afb4a));
        clk      = 1'b0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        test_register_access();
        test_exact_products();
        test_zero_operands();
        test_run_timing();
        test_shift_saturation();
        test_busy_writes();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: lenet_conv_top.sv
`timescale 1ns/1ps

module lenet_conv_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [lenet_pkg::wb_addr_width-1:0] wb_adr,
    input  logic [lenet_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [lenet_pkg::wb_data_width-1:0] wb_dat_r,
    output logic                                wb_ack
);

    logic [lenet_pkg::tap_index_width-1:0] tap_index;
    logic [lenet_pkg::data_width-1:0]      weight;
    logic [lenet_pkg::data_width-1:0]      pixel;
    logic                                  start;
    logic [lenet_pkg::shift_width-1:0]     shift;
    logic [lenet_pkg::acc_width-1:0]       bias;
    logic                                  busy;
    logic                                  result_valid;
    logic [lenet_pkg::acc_width-1:0]       acc;
    logic [lenet_pkg::data_width-1:0]      act;

    lenet_wb_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .tap_index    (tap_index),
        .weight       (weight),
        .pixel        (pixel),
        .start        (start),
        .shift        (shift),
        .bias         (bias),
        .busy         (busy),
        .result_valid (result_valid),
        .acc          (acc),
        .act          (act)
    );

    lenet_conv_mac u_mac (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .shift        (shift),
        .bias         (bias),
        .weight       (weight),
        .pixel        (pixel),
        .tap_index    (tap_index),
        .busy         (busy),
        .result_valid (result_valid),
        .acc          (acc),
        .act          (act)
    );

endmodule

// File: lenet_wb_regs.sv
`timescale 1ns/1ps

module lenet_wb_regs (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [lenet_pkg::wb_addr_width-1:0]   wb_adr,
    input  logic [lenet_pkg::wb_data_width-1:0]   wb_dat_w,
    output logic [lenet_pkg::wb_data_width-1:0]   wb_dat_r,
    output logic                                  wb_ack,
    input  logic [lenet_pkg::tap_index_width-1:0] tap_index,
    output logic [lenet_pkg::data_width-1:0]      weight,
    output logic [lenet_pkg::data_width-1:0]      pixel,
    output logic                                  start,
    output logic [lenet_pkg::shift_width-1:0]     shift,
    output logic [lenet_pkg::acc_width-1:0]       bias,
    input  logic                                  busy,
    input  logic                                  result_valid,
    input  logic [lenet_pkg::acc_width-1:0]       acc,
    input  logic [lenet_pkg::data_width-1:0]      act
);

    logic                                  ack_q;
    logic [lenet_pkg::wb_data_width-1:0]   dat_q;
    logic                                  start_q;
    logic                                  done_q;
    logic [lenet_pkg::shift_width-1:0]     shift_q;
    logic [lenet_pkg::acc_width-1:0]       bias_q;
    logic [lenet_pkg::acc_width-1:0]       acc_q;
    logic [lenet_pkg::data_width-1:0]      act_q;
    logic [lenet_pkg::data_width-1:0]      weight_mem [lenet_pkg::num_taps];
    logic [lenet_pkg::data_width-1:0]      pixel_mem [lenet_pkg::num_taps];

    logic                                  access;
    logic                                  wr_en;
    logic                                  start_req;
    logic [lenet_pkg::wb_addr_width-1:0]   weight_off;
    logic [lenet_pkg::wb_addr_width-1:0]   pixel_off;
    logic                                  weight_hit;
    logic                                  pixel_hit;
    logic [lenet_pkg::tap_index_width-1:0] weight_idx;
    logic [lenet_pkg::tap_index_width-1:0] pixel_idx;
    logic [lenet_pkg::wb_data_width-1:0]   rd_data;

    assign access = wb_cyc & wb_stb & ~ack_q; // first cycle of a bus cycle
    assign wr_en  = access & wb_we & ~busy;

    assign start_req = wr_en & (wb_adr == lenet_pkg::reg_ctrl) & wb_dat_w[0];

    assign weight_off = wb_adr - lenet_pkg::weight_base;
    assign pixel_off  = wb_adr - lenet_pkg::pixel_base;
    assign weight_hit = (int'(weight_off) < lenet_pkg::num_taps);
    assign pixel_hit  = (int'(pixel_off) < lenet_pkg::num_taps);
    assign weight_idx = weight_off[lenet_pkg::tap_index_width-1:0];
    assign pixel_idx  = pixel_off[lenet_pkg::tap_index_width-1:0];

    // host side writes and the result latch
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= '0;
            bias_q  <= '0;
            acc_q   <= '0;
            act_q   <= '0;
            for (int i = 0; i < lenet_pkg::num_taps; i++) begin
                weight_mem[i] <= '0;
                pixel_mem[i]  <= '0;
            end
        end else begin
            if (wr_en) begin
                if (wb_adr == lenet_pkg::reg_shift) begin
                    shift_q <= wb_dat_w[lenet_pkg::shift_width-1:0];
                end
                if (wb_adr == lenet_pkg::reg_bias) begin
                    bias_q <= wb_dat_w[lenet_pkg::acc_width-1:0];
                end
                if (weight_hit) begin
                    weight_mem[weight_idx] <= wb_dat_w[lenet_pkg::data_width-1:0];
                end
                if (pixel_hit) begin
                    pixel_mem[pixel_idx] <= wb_dat_w[lenet_pkg::data_width-1:0];
                end
            end
            if (result_valid) begin
                acc_q <= acc;
                act_q <= act;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q   <= 1'b0;
            dat_q   <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            ack_q   <= access;
            start_q <= start_req; // single cycle pulse
            if (access) begin
                dat_q <= rd_data;
            end
            if (start_req) begin
                done_q <= 1'b0;
            end else if (result_valid) begin
                done_q <= 1'b1;
            end
        end
    end

    // unmapped addresses and reg_ctrl read back as zero
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            lenet_pkg::reg_status: rd_data[1:0] = {done_q, busy};
            lenet_pkg::reg_shift:  rd_data[lenet_pkg::shift_width-1:0] = shift_q;
            lenet_pkg::reg_bias:   rd_data[lenet_pkg::acc_width-1:0] = bias_q;
            lenet_pkg::reg_acc:    rd_data[lenet_pkg::acc_width-1:0] = acc_q;
            lenet_pkg::reg_act:    rd_data[lenet_pkg::data_width-1:0] = act_q;
            default: begin
                if (weight_hit) begin
                    rd_data[lenet_pkg::data_width-1:0] = weight_mem[weight_idx];
                end else if (pixel_hit) begin
                    rd_data[lenet_pkg::data_width-1:0] = pixel_mem[pixel_idx];
                end
            end
        endcase
    end

    assign wb_dat_r = dat_q;
    assign wb_ack   = ack_q;
    assign start    = start_q;
    assign shift    = shift_q;
    assign bias     = bias_q;
    assign weight   = weight_mem[tap_index]; // engine side read
    assign pixel    = pixel_mem[tap_index];

endmodule

// File: lenet_conv_mac.sv
`timescale 1ns/1ps

module lenet_conv_mac (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start,
    input  logic [lenet_pkg::shift_width-1:0]     shift,
    input  logic [lenet_pkg::acc_width-1:0]       bias,
    input  logic [lenet_pkg::data_width-1:0]      weight,
    input  logic [lenet_pkg::data_width-1:0]      pixel,
    output logic [lenet_pkg::tap_index_width-1:0] tap_index,
    output logic                                  busy,
    output logic                                  result_valid,
    output logic [lenet_pkg::acc_width-1:0]       acc,
    output logic [lenet_pkg::data_width-1:0]      act
);

    lenet_pkg::mac_state_t state;

    logic [lenet_pkg::tap_index_width-1:0] tap_q;
    logic                                  last_tap;
    logic [lenet_pkg::prod_width-1:0]      mult_z;
    logic [lenet_pkg::prod_width-1:0]      prod_q;
    logic                                  prod_valid;
    logic [lenet_pkg::acc_width-1:0]       acc_q;
    logic [lenet_pkg::acc_width-1:0]       sum_next;
    logic [lenet_pkg::acc_width-1:0]       sum_shifted;
    logic [lenet_pkg::data_width-1:0]      act_q;
    logic [lenet_pkg::data_width-1:0]      act_next;

    lenet_xwyf_34 u_mult (
        .x (weight),
        .y (pixel),
        .z (mult_z)
    );

    assign last_tap = (int'(tap_q) == lenet_pkg::num_taps - 1);

    // idle -> run (25 taps) -> drain (last add) -> finish (result out)
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lenet_pkg::mac_idle;
            tap_q <= '0;
        end else begin
            case (state)
                lenet_pkg::mac_idle: begin
                    tap_q <= '0;
                    if (start) begin
                        state <= lenet_pkg::mac_run;
                    end
                end
                lenet_pkg::mac_run: begin
                    if (last_tap) begin
                        state <= lenet_pkg::mac_drain;
                        tap_q <= '0;
                    end else begin
                        tap_q <= tap_q + 1'b1;
                    end
                end
                lenet_pkg::mac_drain: begin
                    state <= lenet_pkg::mac_finish;
                end
                default: begin
                    state <= lenet_pkg::mac_idle;
                end
            endcase
        end
    end

    // one product behind each issued tap
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= (state == lenet_pkg::mac_run);
        end
    end

    assign sum_next    = acc_q + lenet_pkg::acc_width'(prod_q);
    assign sum_shifted = sum_next >> shift;

    // clamp to 255 when anything lands above the low byte
    always_comb begin
        if (|sum_shifted[lenet_pkg::acc_width-1:lenet_pkg::data_width]) begin
            act_next = '1;
        end else begin
            act_next = sum_shifted[lenet_pkg::data_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        prod_q <= mult_z;
        if (state == lenet_pkg::mac_idle && start) begin
            acc_q <= bias; // bias preset
        end else if (prod_valid) begin
            acc_q <= sum_next;
        end
        if (state == lenet_pkg::mac_drain) begin
            act_q <= act_next; // built from the final sum
        end
    end

    assign tap_index    = tap_q;
    assign busy         = (state != lenet_pkg::mac_idle);
    assign result_valid = (state == lenet_pkg::mac_finish);
    assign acc          = acc_q;
    assign act          = act_q;

endmodule

// File: lenet_xwyf_34.sv
`timescale 1ns/1ps

module lenet_xwyf_34 (
    input  logic [7:0]  x,
    input  logic [7:0]  y,
    output logic [15:0] z
);

    logic [7:0]  pp [8];
    logic [12:0] corr1;
    logic [12:0] corr2;
    logic [12:0] corr3;
    logic [12:0] corr4;
    logic [12:0] corr5;

    // one row of y per bit of x
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // rows 0..5 are compressed into sparse correction words,
    // rows 6 and 7 are added exactly below
    always_comb begin
        corr1 = '0;
        corr2 = '0;
        corr3 = '0;
        corr4 = '0;
        corr5 = '0;

        corr1[3]  = pp[0][3] & pp[1][2];
        corr1[4]  = pp[2][1] & pp[3][0];
        corr1[5]  = pp[2][3] ^ pp[3][2];
        corr1[6]  = pp[2][4] ^ pp[3][3];
        corr1[7]  = pp[2][5] & pp[3][4];
        corr1[8]  = pp[0][7] | pp[1][6];
        corr1[9]  = pp[2][7] | pp[3][6];
        corr1[10] = pp[2][7] & pp[3][6];
        corr1[11] = pp[4][7] & pp[5][6];
        corr1[12] = pp[5][7];

        corr2[3]  = pp[2][1] & pp[3][0];
        corr2[4]  = pp[2][2] | pp[3][1];
        corr2[6]  = pp[4][2] ^ pp[5][1];
        corr2[7]  = pp[4][3] | pp[5][2];
        corr2[8]  = pp[2][5] | pp[3][4];
        corr2[9]  = pp[4][4] & pp[5][3];
        corr2[10] = pp[3][7];
        corr2[11] = pp[4][7] | pp[5][6];

        corr3[8]  = pp[2][6] | pp[3][5];
        corr3[9]  = pp[4][5] ^ pp[5][4];
        corr3[10] = pp[4][5] & pp[5][4];

        corr4[8]  = pp[4][3] & pp[5][2];
        corr4[10] = pp[4][6] & pp[5][5];

        corr5[8]  = pp[4][4] ^ pp[5][3];
        corr5[10] = pp[4][6] | pp[5][5];
    end

    assign z = {2'b00, pp[6], 6'b000000}
             + {1'b0, pp[7], 7'b0000000}
             + {3'b000, corr1}
             + {3'b000, corr2}
             + {3'b000, corr3}
             + {3'b000, corr4}
             + {3'b000, corr5};

endmodule

// File: lenet_pkg.sv
package lenet_pkg;

    // datapath widths
    localparam int data_width      = 8;
    localparam int prod_width      = 16;
    localparam int acc_width       = 24;

    // bus widths
    localparam int wb_data_width   = 32;
    localparam int wb_addr_width   = 8;

    // kernel geometry, 5x5 window
    localparam int num_taps        = 25;
    localparam int tap_index_width = 5;
    localparam int shift_width     = 4;

    // word addresses
    localparam logic [wb_addr_width-1:0] reg_ctrl    = 8'h00; // bit 0 starts a run
    localparam logic [wb_addr_width-1:0] reg_status  = 8'h01; // bit 0 busy, bit 1 done
    localparam logic [wb_addr_width-1:0] reg_shift   = 8'h02;
    localparam logic [wb_addr_width-1:0] reg_bias    = 8'h03;
    localparam logic [wb_addr_width-1:0] reg_acc     = 8'h04; // read only
    localparam logic [wb_addr_width-1:0] reg_act     = 8'h05; // read only
    localparam logic [wb_addr_width-1:0] weight_base = 8'h20; // 0x20 .. 0x38
    localparam logic [wb_addr_width-1:0] pixel_base  = 8'h40; // 0x40 .. 0x58

    // tap sequencer
    typedef enum logic [1:0] {
        mac_idle,
        mac_run,
        mac_drain,
        mac_finish
    } mac_state_t;

endpackage
